// ==== project.f ====
+incdir+logic
logic/bru_pkg.sv
logic/bjp_decode.sv
logic/exu_bru.sv
logic/pc_sequencer.sv
logic/bru_stage.sv
verif/bru_checker.sv
verif/bru_tb.sv

// ==== Bender.yml ====
package:
  name: bru_stage

export_include_dirs:
  - logic

sources:
  - files:
      - logic/bru_pkg.sv
      - logic/bjp_decode.sv
      - logic/exu_bru.sv
      - logic/pc_sequencer.sv
      - logic/bru_stage.sv
  - target: test
    files:
      - verif/bru_checker.sv
      - verif/bru_tb.sv

// ==== verif/bru_tb.sv ====
// self-checking testbench for the branch slice
// random instructions from a fixed-seed lfsr at one per cycle with no back-pressure
// expected values come from a behavioural model of the RV32I control-flow rules
// interrupt addresses are always word aligned as the sequencer expects

`timescale 1ns/1ps

`include "bru_config.svh"

module bru_tb;

    localparam int          NUM_TESTS    = 2000;
    localparam int          RESET_CYCLES = 16;
    localparam int          PERIOD       = 100;
    localparam logic [31:0] SEED         = 32'heb0a_4589;

    typedef struct packed {
        logic           jump;
        bru_pkg::addr_t addr;
        logic           mis;
        bru_pkg::addr_t next_pc;
    } expect_t;

    logic           clk;
    logic           rst_i;
    logic           instr_valid_i;
    bru_pkg::inst_u instr_i;
    bru_pkg::addr_t rs1_i;
    bru_pkg::addr_t rs2_i;
    logic           int_assert_i;
    bru_pkg::addr_t int_addr_i;
    bru_pkg::addr_t pc_o;
    logic           jump_flag_o;
    bru_pkg::addr_t jump_addr_o;
    logic           misaligned_o;

    logic [31:0]    lfsr;
    bru_pkg::addr_t exp_pc;        // model pc that tracks the instruction address
    expect_t        exp;
    int             flag_errors;
    int             addr_errors;

    bru_stage UUT (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .int_assert_i  (int_assert_i),
        .int_addr_i    (int_addr_i),
        .pc_o          (pc_o),
        .jump_flag_o   (jump_flag_o),
        .jump_addr_o   (jump_addr_o),
        .misaligned_o  (misaligned_o)
    );

    always #(PERIOD / 2) clk = ~clk;

    // galois step for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // n fresh bits with one lfsr step each
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // expected outputs and next pc straight from the isa encodings
    function automatic expect_t ref_model(input logic valid, input logic [31:0] w,
                                          input bru_pkg::addr_t pc, input bru_pkg::addr_t a,
                                          input bru_pkg::addr_t b, input logic irq,
                                          input bru_pkg::addr_t irq_pc);
        expect_t        r;
        bru_pkg::addr_t imm;
        bru_pkg::addr_t tgt;
        logic           is_br;
        logic           cond;
        logic           pred;
        logic           taken;
        logic           redirect;
        imm      = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};  // b-type offset
        tgt      = pc + `BRU_INST_STEP;
        is_br    = valid && (w[6:0] == bru_pkg::OPC_BRANCH) && (w[14:13] != 2'b01);
        pred     = is_br && w[31];                                 // backward
        taken    = 1'b0;
        redirect = 1'b0;
        case (w[14:12])
            3'b000:  cond = (a == b);
            3'b001:  cond = (a != b);
            3'b100:  cond = ($signed(a) < $signed(b));
            3'b101:  cond = ($signed(a) >= $signed(b));
            3'b110:  cond = (a < b);
            default: cond = (a >= b);   // 111 only since illegal ones never reach is_br
        endcase
        if (is_br && cond) begin
            tgt      = pc + imm;
            taken    = 1'b1;
            redirect = !pred;          // predicted ones are already there
        end else if (pred) begin
            redirect = 1'b1;           // rollback to pc + 4
        end else if (valid && w[6:0] == bru_pkg::OPC_JAL) begin
            tgt      = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            taken    = 1'b1;
            redirect = 1'b1;
        end else if (valid && w[6:0] == bru_pkg::OPC_JALR) begin
            tgt      = (a + {{20{w[31]}}, w[31:20]}) & ~32'd1;
            taken    = 1'b1;
            redirect = 1'b1;
        end else if (valid && w[6:0] == bru_pkg::OPC_FENCE) begin
            redirect = 1'b1;
        end
        r.addr = tgt;
        r.mis  = taken && (tgt[1:0] != 2'b00);
        r.jump = redirect && !r.mis && !irq;
        if (irq) r.next_pc = irq_pc;
        else if (r.mis) r.next_pc = pc;
        else if (r.jump) r.next_pc = tgt;
        else if (pred) r.next_pc = pc + imm;
        else if (valid) r.next_pc = pc + `BRU_INST_STEP;
        else r.next_pc = pc;
        return r;
    endfunction

    task automatic check_addr(input bru_pkg::addr_t got, input bru_pkg::addr_t want,
                              input string what);
        if (got !== want) begin
            addr_errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            flag_errors++;
            $display("FAILED %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    // one random instruction with its operands
    task automatic drive_random();
        bru_pkg::inst_u w;
        bru_pkg::addr_t a;
        bru_pkg::addr_t b;
        logic [31:0]    off;
        logic [2:0]     cls;
        logic           neg;
        logic           lsb;
        w   = rand_bits(32);                                  // noise in unused fields
        cls = rand_bits(3);
        neg = rand_bits(1);
        off = rand_bits(1) ? rand_bits(9) : rand_bits(4);     // far or near
        off = {off[29:0], (rand_bits(2) == 0), 1'b0};         // bit 1 set now and then
        lsb = rand_bits(1);
        if (neg) off = -off;
        a = rand_bits(32);
        case (rand_bits(2))
            2'd0:    b = a;
            2'd1:    b = a + 1;
            2'd2:    b = a - 1;
            default: b = a ^ 32'h8000_0000;                   // signed vs unsigned split
        endcase
        case (cls)
            3'd0, 3'd1, 3'd2: begin
                w.b.opcode   = bru_pkg::OPC_BRANCH;
                w.b.funct3   = rand_bits(3);
                w.b.imm_12   = off[12];
                w.b.imm_11   = off[11];
                w.b.imm_10_5 = off[10:5];
                w.b.imm_4_1  = off[4:1];
            end
            3'd3: begin
                w.ij.opcode             = bru_pkg::OPC_JAL;
                w.ij.imm                = {off[20], off[10:1], off[11]};
                {w.ij.rs1, w.ij.funct3} = off[19:12];
            end
            3'd4: begin
                w.ij.opcode = bru_pkg::OPC_JALR;
                w.ij.funct3 = 3'b000;
                w.ij.imm    = {off[11:1], lsb};               // dut clears bit 0
                if (rand_bits(1)) a[1:0] = 2'b00;
            end
            3'd5:    w.ij.opcode = bru_pkg::OPC_FENCE;
            default: w.ij.opcode = bru_pkg::OPC_OTHER;
        endcase
        instr_valid_i <= (rand_bits(3) != 0);
        instr_i       <= w;
        rs1_i         <= a;
        rs2_i         <= b;
        int_assert_i  <= (rand_bits(5) == 0);                 // rare
        int_addr_i    <= rand_bits(30) << 2;
    endtask

    // flags and address mid-cycle plus pc_o of the previous instruction
    always @(negedge clk) begin
        if (rst_i) begin
            exp_pc = `BRU_RESET_PC;
        end else begin
            check_addr(pc_o, exp_pc, "pc_o");
            exp = ref_model(instr_valid_i, instr_i, exp_pc, rs1_i, rs2_i,
                            int_assert_i, int_addr_i);
            check_flag(jump_flag_o, exp.jump, "jump_flag_o");
            check_flag(misaligned_o, exp.mis, "misaligned_o");
            if (exp.jump || exp.mis) check_addr(jump_addr_o, exp.addr, "jump_addr_o");
            exp_pc = exp.next_pc;
        end
    end

    initial begin
        clk           = 1'b0;
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_i         = '0;
        rs2_i         = '0;
        int_assert_i  = 1'b0;
        int_addr_i    = '0;
        lfsr          = SEED;
        flag_errors   = 0;
        addr_errors   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);                                       // one idle cycle first
        repeat (NUM_TESTS) begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);
        instr_valid_i <= 1'b0;
        int_assert_i  <= 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: %0d flag, %0d address, %0d assertion", flag_errors, addr_errors,
                 UUT.u_checker.assert_errors);
        if (flag_errors + addr_errors + UUT.u_checker.assert_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((NUM_TESTS + RESET_CYCLES + 20) * PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== verif/bru_checker.sv ====
// concurrent checks on the branch slice outputs bound into bru_stage
// sampled on the rising edge and disabled while reset is high

`timescale 1ns/1ps

module bru_checker (
    input logic           clk,
    input logic           rst_i,
    input logic           int_assert_i,
    input bru_pkg::addr_t int_addr_i,
    input logic           jump_flag_i,
    input logic           misaligned_i,
    input bru_pkg::addr_t pc_i
);

    int assert_errors = 0;    // failed assertions so far

    // bad target drops the redirect
    a_flag_vs_mis: assert property (@(posedge clk) disable iff (rst_i)
        !(jump_flag_i && misaligned_i))
        else begin
            $error("jump_flag_o and misaligned_o high in the same cycle");
            assert_errors++;
        end

    // bad target also keeps the fetch pc where it is
    a_mis_hold: assert property (@(posedge clk) disable iff (rst_i)
        (misaligned_i && !int_assert_i) |=> pc_i == $past(pc_i))
        else begin
            $error("pc_o moved after a misaligned target");
            assert_errors++;
        end

    // interrupt wins over any redirect
    a_irq_mask: assert property (@(posedge clk) disable iff (rst_i)
        int_assert_i |-> !jump_flag_i)
        else begin
            $error("jump_flag_o high while int_assert_i is high");
            assert_errors++;
        end

    // interrupt entry lands in the pc one edge later
    a_irq_load: assert property (@(posedge clk) disable iff (rst_i)
        int_assert_i |=> pc_i == $past(int_addr_i))
        else begin
            $error("pc_o did not load int_addr_i after an interrupt");
            assert_errors++;
        end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst_i)
        pc_i[1:0] == 2'b00)
        else begin
            $error("pc_o is not word aligned");
            assert_errors++;
        end

endmodule

bind bru_stage bru_checker u_checker (
    .clk          (clk),
    .rst_i        (rst_i),
    .int_assert_i (int_assert_i),
    .int_addr_i   (int_addr_i),
    .jump_flag_i  (jump_flag_o),
    .misaligned_i (misaligned_o),
    .pc_i         (pc_o)
);

// ==== logic/bru_stage.sv ====
// top of the branch slice: decode -> resolve -> pc register
// one instruction per cycle at the registered pc, no back-pressure
// jump_flag / jump_addr / misaligned are combinational, pc_o moves
// on the following rising edge

`timescale 1ns/1ps

module bru_stage (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            instr_valid_i,    // one-cycle qualifier
    input  bru_pkg::inst_u  instr_i,
    input  bru_pkg::addr_t  rs1_i,
    input  bru_pkg::addr_t  rs2_i,
    input  logic            int_assert_i,
    input  bru_pkg::addr_t  int_addr_i,

    output bru_pkg::addr_t  pc_o,
    output logic            jump_flag_o,
    output bru_pkg::addr_t  jump_addr_o,
    output logic            misaligned_o
);

    // decoder to branch unit
    logic           req_bjp;
    logic           op_beq;
    logic           op_bne;
    logic           op_blt;
    logic           op_bltu;
    logic           op_bge;
    logic           op_bgeu;
    logic           op_jal;
    logic           op_jalr;
    logic           op_fence;
    bru_pkg::addr_t bjp_op1;
    bru_pkg::addr_t bjp_op2;
    bru_pkg::addr_t jump_op1;
    bru_pkg::addr_t jump_op2;
    logic           is_pred_branch;   // also feeds the sequencer
    bru_pkg::addr_t pred_target;

    bjp_decode u_decode (
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .pc_i             (pc_o),          // instruction sits at the current pc
        .rs1_i            (rs1_i),
        .rs2_i            (rs2_i),
        .req_bjp_o        (req_bjp),
        .op_beq_o         (op_beq),
        .op_bne_o         (op_bne),
        .op_blt_o         (op_blt),
        .op_bltu_o        (op_bltu),
        .op_bge_o         (op_bge),
        .op_bgeu_o        (op_bgeu),
        .op_jal_o         (op_jal),
        .op_jalr_o        (op_jalr),
        .op_fence_o       (op_fence),
        .bjp_op1_o        (bjp_op1),
        .bjp_op2_o        (bjp_op2),
        .jump_op1_o       (jump_op1),
        .jump_op2_o       (jump_op2),
        .is_pred_branch_o (is_pred_branch),
        .pred_target_o    (pred_target)
    );

    exu_bru u_bru (
        .req_bjp_i          (req_bjp),
        .op_beq_i           (op_beq),
        .op_bne_i           (op_bne),
        .op_blt_i           (op_blt),
        .op_bltu_i          (op_bltu),
        .op_bge_i           (op_bge),
        .op_bgeu_i          (op_bgeu),
        .op_jal_i           (op_jal),
        .op_jalr_i          (op_jalr),
        .bjp_op1_i          (bjp_op1),
        .bjp_op2_i          (bjp_op2),
        .jump_op1_i         (jump_op1),
        .jump_op2_i         (jump_op2),
        .is_pred_branch_i   (is_pred_branch),
        .sys_op_fence_i     (op_fence),
        .int_assert_i       (int_assert_i),
        .jump_flag_o        (jump_flag_o),
        .jump_addr_o        (jump_addr_o),
        .misaligned_fetch_o (misaligned_o)
    );

    pc_sequencer u_seq (
        .clk                (clk),
        .rst_i              (rst_i),
        .instr_valid_i      (instr_valid_i),
        .int_assert_i       (int_assert_i),
        .int_addr_i         (int_addr_i),
        .jump_flag_i        (jump_flag_o),
        .jump_addr_i        (jump_addr_o),
        .misaligned_fetch_i (misaligned_o),
        .is_pred_branch_i   (is_pred_branch),
        .pred_target_i      (pred_target),
        .pc_o               (pc_o)
    );

endmodule

// ==== logic/pc_sequencer.sv ====
// fetch pc register
// next pc picked by fixed priority: interrupt, misaligned hold, redirect,
// predicted target, sequential step, idle hold
// all select inputs are taken as already qualified by instr_valid_i
// except the sequential step, which checks it here
// synchronous active-high reset to BRU_RESET_PC

`timescale 1ns/1ps

`include "bru_config.svh"

module pc_sequencer (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            instr_valid_i,
    input  logic            int_assert_i,
    input  bru_pkg::addr_t  int_addr_i,       // interrupt entry, word aligned
    input  logic            jump_flag_i,
    input  bru_pkg::addr_t  jump_addr_i,
    input  logic            misaligned_fetch_i,
    input  logic            is_pred_branch_i,
    input  bru_pkg::addr_t  pred_target_i,

    output bru_pkg::addr_t  pc_o
);

    bru_pkg::addr_t pc_q;
    bru_pkg::addr_t pc_next;

    // priority mux
    always_comb begin
        if (int_assert_i) begin
            pc_next = int_addr_i;           // interrupt wins over everything
        end else if (misaligned_fetch_i) begin
            pc_next = pc_q;                 // stay put, trap handling is elsewhere
        end else if (jump_flag_i) begin
            pc_next = jump_addr_i;          // redirect or rollback
        end else if (is_pred_branch_i) begin
            pc_next = pred_target_i;        // backward branch, go early
        end else if (instr_valid_i) begin
            pc_next = pc_q + bru_pkg::addr_t'(`BRU_INST_STEP);
        end else begin
            pc_next = pc_q;                 // no instruction, no move
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `BRU_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== logic/exu_bru.sv ====
// branch resolution, purely combinational
// jump_op1/op2 arrive already selected by the decoder (pc or rs1, offset)
// a rollback reuses the target adder with +4, so jump_op1 must be the pc
// for branches
// jump_flag is masked by a misaligned target and by a pending interrupt;
// misaligned_fetch itself is not masked by the interrupt

`timescale 1ns/1ps

`include "bru_config.svh"

module exu_bru (
    input  logic            req_bjp_i,
    input  logic            op_beq_i,
    input  logic            op_bne_i,
    input  logic            op_blt_i,
    input  logic            op_bltu_i,
    input  logic            op_bge_i,
    input  logic            op_bgeu_i,
    input  logic            op_jal_i,
    input  logic            op_jalr_i,
    input  bru_pkg::addr_t  bjp_op1_i,
    input  bru_pkg::addr_t  bjp_op2_i,
    input  bru_pkg::addr_t  jump_op1_i,
    input  bru_pkg::addr_t  jump_op2_i,
    input  logic            is_pred_branch_i,  // front end already went to target
    input  logic            sys_op_fence_i,
    input  logic            int_assert_i,

    output logic            jump_flag_o,
    output bru_pkg::addr_t  jump_addr_o,
    output logic            misaligned_fetch_o
);

    logic           eq;
    logic           lt_s;
    logic           lt_u;
    logic           taken;       // real outcome incl. unconditional jumps
    logic           rollback;    // predicted taken, actually not
    logic           jump_raw;
    bru_pkg::addr_t add_b;
    bru_pkg::addr_t sum;

    // compares on the register operands
    assign eq   = (bjp_op1_i == bjp_op2_i);
    assign lt_s = $signed(bjp_op1_i) < $signed(bjp_op2_i);
    assign lt_u = bjp_op1_i < bjp_op2_i;

    always_comb begin
        taken = 1'b0;
        if (req_bjp_i) begin
            taken = (op_beq_i  &  eq)   |
                    (op_bne_i  & ~eq)   |
                    (op_blt_i  &  lt_s) |
                    (op_bge_i  & ~lt_s) |
                    (op_bltu_i &  lt_u) |
                    (op_bgeu_i & ~lt_u) |
                    op_jal_i | op_jalr_i;
        end
    end

    assign rollback = req_bjp_i & is_pred_branch_i & ~taken;

    // one adder, swapped to +4 when undoing a prediction
    assign add_b = rollback ? bru_pkg::addr_t'(`BRU_INST_STEP) : jump_op2_i;
    assign sum   = jump_op1_i + add_b;

    // jalr drops bit 0 per spec
    assign jump_addr_o = op_jalr_i ? (sum & ~bru_pkg::addr_t'(1)) : sum;

    // predicted-and-taken needs no redirect
    assign jump_raw = (taken & ~is_pred_branch_i) | sys_op_fence_i | rollback;

    // any taken transfer to a non-word address, predicted ones included
    assign misaligned_fetch_o = (jump_addr_o[1:0] != 2'b00) & (jump_raw | taken);

    assign jump_flag_o = jump_raw & ~misaligned_fetch_o & ~int_assert_i;

endmodule

// ==== logic/bjp_decode.sv ====
// branch / jump predecode for one instruction per cycle
// all outputs are combinational from the current pc and operands
// only beq/bne/blt/bge/bltu/bgeu, jal, jalr and fence are recognised;
// illegal branch funct3 values raise no strobe at all
// static prediction: backward branches taken, forward not taken

`timescale 1ns/1ps

`include "bru_config.svh"

module bjp_decode (
    input  logic            instr_valid_i,
    input  bru_pkg::inst_u  instr_i,
    input  bru_pkg::addr_t  pc_i,
    input  bru_pkg::addr_t  rs1_i,
    input  bru_pkg::addr_t  rs2_i,

    output logic            req_bjp_o,       // branch, jal or jalr this cycle
    output logic            op_beq_o,
    output logic            op_bne_o,
    output logic            op_blt_o,
    output logic            op_bltu_o,
    output logic            op_bge_o,
    output logic            op_bgeu_o,
    output logic            op_jal_o,
    output logic            op_jalr_o,
    output logic            op_fence_o,
    output bru_pkg::addr_t  bjp_op1_o,       // compare operands
    output bru_pkg::addr_t  bjp_op2_o,
    output bru_pkg::addr_t  jump_op1_o,      // target adder operands
    output bru_pkg::addr_t  jump_op2_o,
    output logic            is_pred_branch_o,
    output bru_pkg::addr_t  pred_target_o
);

    bru_pkg::opcode_e opc;
    bru_pkg::addr_t   imm_b;       // sign-extended branch offset
    bru_pkg::addr_t   imm_i;       // jalr offset
    bru_pkg::addr_t   imm_j;       // jal offset
    logic             is_branch;
    logic             is_jal;
    logic             is_jalr;
    logic             is_fence;
    logic             f3_legal;
    logic             br_ok;       // valid branch with a known condition
    logic [2:0]       f3;

    assign opc = bru_pkg::opcode_e'(instr_i.b.opcode);
    assign f3  = instr_i.b.funct3;

    // b view, offset bit 0 always zero
    assign imm_b = {{(`BRU_ADDR_W-13){instr_i.b.imm_12}},
                    instr_i.b.imm_12,
                    instr_i.b.imm_11,
                    instr_i.b.imm_10_5,
                    instr_i.b.imm_4_1,
                    1'b0};

    // ij view, plain 12-bit immediate
    assign imm_i = {{(`BRU_ADDR_W-12){instr_i.ij.imm[11]}}, instr_i.ij.imm};

    // ij view again, j-type bits shuffled back into order
    assign imm_j = {{(`BRU_ADDR_W-21){instr_i.ij.imm[11]}},
                    instr_i.ij.imm[11],     // j[20]
                    instr_i.ij.rs1,         // j[19:15]
                    instr_i.ij.funct3,      // j[14:12]
                    instr_i.ij.imm[0],      // j[11]
                    instr_i.ij.imm[10:1],   // j[10:1]
                    1'b0};

    // opcode class, nothing without the valid strobe
    always_comb begin
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_fence  = 1'b0;
        if (instr_valid_i) begin
            case (opc)
                bru_pkg::OPC_BRANCH: is_branch = 1'b1;
                bru_pkg::OPC_JAL:    is_jal    = 1'b1;
                bru_pkg::OPC_JALR:   is_jalr   = 1'b1;
                bru_pkg::OPC_FENCE:  is_fence  = 1'b1;
                default:             ;  // OPC_OTHER and the rest fall through
            endcase
        end
    end

    // funct3 010 / 011 are not branches
    assign f3_legal = (f3 != 3'b010) && (f3 != 3'b011);
    assign br_ok    = is_branch & f3_legal;

    // one-hot strobes
    assign op_beq_o   = br_ok & (f3 == 3'b000);
    assign op_bne_o   = br_ok & (f3 == 3'b001);
    assign op_blt_o   = br_ok & (f3 == 3'b100);
    assign op_bge_o   = br_ok & (f3 == 3'b101);
    assign op_bltu_o  = br_ok & (f3 == 3'b110);
    assign op_bgeu_o  = br_ok & (f3 == 3'b111);
    assign op_jal_o   = is_jal;
    assign op_jalr_o  = is_jalr;
    assign op_fence_o = is_fence;

    assign req_bjp_o = br_ok | is_jal | is_jalr;

    assign bjp_op1_o = rs1_i;
    assign bjp_op2_o = rs2_i;

    // target adder inputs, default pc + 4 covers fence
    always_comb begin
        jump_op1_o = pc_i;
        jump_op2_o = bru_pkg::addr_t'(`BRU_INST_STEP);
        if (is_jalr) begin
            jump_op1_o = rs1_i;   // register relative
            jump_op2_o = imm_i;
        end else if (br_ok) begin
            jump_op2_o = imm_b;
        end else if (is_jal) begin
            jump_op2_o = imm_j;
        end
    end

    // backward offset -> predict taken
    assign is_pred_branch_o = br_ok & imm_b[`BRU_ADDR_W-1];
    assign pred_target_o    = pc_i + imm_b;  // only meaningful when predicted

endmodule

// ==== logic/bru_pkg.sv ====
// shared types for the branch slice
// widths come from bru_config.svh
// opcode list only covers what the decoder recognises, everything else
// counts as OPC_OTHER

`include "bru_config.svh"

package bru_pkg;

    // pc / operand word
    typedef logic [`BRU_ADDR_W-1:0] addr_t;

    // major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_FENCE  = 7'b0001111,
        OPC_OTHER  = 7'b0010011  // op-imm, used as the generic non-control class
    } opcode_e;

    // b-type layout, immediate scattered over two places
    typedef struct packed {
        logic       imm_12;     // sign bit
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } inst_b_t;

    // i-type layout
    // j-type reuses it: imm holds j[20|10:1|11], rs1/funct3 hold j[19:12]
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_ij_t;

    // one instruction word, two decodings
    typedef union packed {
        inst_b_t  b;
        inst_ij_t ij;
    } inst_u;

endpackage

// ==== logic/bru_config.svh ====
// global sizing for the branch slice
// fixed RV32, so the address width is not meant to be changed
// reset pc must be word aligned; the pc checks rely on bits 1:0 being zero
// instruction step assumes no compressed (16-bit) instructions

`ifndef BRU_CONFIG_SVH
`define BRU_CONFIG_SVH

// instruction address width
`define BRU_ADDR_W 32

// fetch pc after reset
`define BRU_RESET_PC 32'h0000_0080

// sequential pc increment, one 32-bit word
`define BRU_INST_STEP 4

`endif
